// ==== build.f ====
common/fir_pkg.sv
common/fir_coeff_pkg.sv
fir/fir_tap_line.sv
fir/fir_symmetric_mac.sv
fir/fir_adder_tree.sv
source/fir_filter.sv
tb/fir_checker.sv
tb/tb_fir_filter.sv

// ==== common/fir_coeff_pkg.sv ====
// fixed low-pass coefficient set for the 42-tap symmetric FIR
// only the first half is stored, the second half mirrors it
// entry k scales the sum of tap k and tap NUM_TAPS-1-k
package fir_coeff_pkg;

	// ************************************************
	// unique coefficients, outer pair first
	// ************************************************
	localparam fir_pkg::sample_t COEFFS [fir_pkg::NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		// negative lobe bottoms out here
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252,
		18'sd1514,
		// centre pair, taps 20 and 21
		18'sd1756
	};

endpackage

// ==== common/fir_pkg.sv ====
// types and sizes shared by the symmetric FIR datapath
// every sum and product wraps at SAMPLE_W bits and no growth bits are kept
// NUM_TAPS must stay even so that every tap has a mirrored partner
package fir_pkg;

	// sample, coefficient and arithmetic width
	localparam int SAMPLE_W = 18;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// ************************************************
	// filter size
	// ************************************************
	localparam int NUM_TAPS = 42;

	// one coefficient per mirrored tap pair
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// levels needed to reduce NUM_UNIQ operands to one
	localparam int TREE_LEVELS = $clog2(NUM_UNIQ);

	// enabled edges from input capture to o_out
	// tap line plus pre-add and product registers plus one per tree level
	localparam int LATENCY = 1 + 2 + TREE_LEVELS;

	// ************************************************
	// vector types
	// ************************************************
	// index 0 holds the newest sample
	typedef sample_t [NUM_TAPS-1:0] tap_vec_t;

	// one product per unique coefficient
	typedef sample_t [NUM_UNIQ-1:0] prod_vec_t;

endpackage

// ==== fir/fir_adder_tree.sv ====
// registered adder tree reducing NUM_UNIQ products to one sum
// one register level per tree level, odd operands ride a pass register
// sums wrap at SAMPLE_W bits
`timescale 1ns/1ps

module fir_adder_tree (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_clk_ena,
	input  fir_pkg::prod_vec_t i_products,
	output fir_pkg::sample_t   o_sum
);
	import fir_pkg::*;

	// operands entering a level, 21 11 6 3 2 1 for the default size
	function automatic int level_count(input int level);
		int n;
		n = NUM_UNIQ;
		for (int i = 0; i < level; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	// first node of a level in the flat node array
	function automatic int level_base(input int level);
		int base;
		base = 0;
		for (int i = 0; i < level; i++) begin
			base += level_count(i);
		end
		return base;
	endfunction

	localparam int NODES = level_base(TREE_LEVELS + 1);

	// level 0 holds the MAC products, later levels hold tree registers
	sample_t node [NODES];

	for (genvar i = 0; i < NUM_UNIQ; i++) begin : g_leaf
		assign node[i] = i_products[i];
	end

	// ************************************************
	// tree levels
	// ************************************************
	for (genvar l = 0; l < TREE_LEVELS; l++) begin : g_level
		localparam int IN_N     = level_count(l);
		localparam int OUT_N    = level_count(l + 1);
		localparam int IN_BASE  = level_base(l);
		localparam int OUT_BASE = level_base(l + 1);

		for (genvar j = 0; j < OUT_N; j++) begin : g_node
			if (2 * j + 1 < IN_N) begin : g_add
				always_ff @(posedge clk or posedge reset) begin
					if (reset) begin
						node[OUT_BASE + j] <= '0;
					end else if (i_clk_ena) begin
						node[OUT_BASE + j] <= node[IN_BASE + 2 * j] +
							node[IN_BASE + 2 * j + 1];
					end
				end
			end else begin : g_pass
				// last operand of an odd level, delayed to stay in step
				always_ff @(posedge clk or posedge reset) begin
					if (reset) begin
						node[OUT_BASE + j] <= '0;
					end else if (i_clk_ena) begin
						node[OUT_BASE + j] <= node[IN_BASE + 2 * j];
					end
				end
			end
		end
	end

	// root of the tree
	assign o_sum = node[NODES-1];

endmodule

// ==== fir/fir_symmetric_mac.sv ====
// pre-adds mirrored taps and scales each pair by its coefficient
// two register stages, both wrapping at SAMPLE_W bits
// relies on the coefficient set being symmetric about the centre
`timescale 1ns/1ps

module fir_symmetric_mac (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_clk_ena,
	input  fir_pkg::tap_vec_t  i_taps,
	output fir_pkg::prod_vec_t o_products
);
	import fir_pkg::*;
	import fir_coeff_pkg::*;

	prod_vec_t pre_sum_q;
	prod_vec_t product_q;

	// ************************************************
	// stage 1 pre-add of mirrored taps
	// ************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pre_sum_q <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				// tap k pairs with tap NUM_TAPS-1-k
				pre_sum_q[k] <= i_taps[k] + i_taps[NUM_TAPS-1-k];
			end
		end
	end

	// ************************************************
	// stage 2 coefficient multiply
	// ************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			product_q <= '0;
		end else if (i_clk_ena) begin
			for (int k = 0; k < NUM_UNIQ; k++) begin
				// low SAMPLE_W bits of the product only
				product_q[k] <= pre_sum_q[k] * COEFFS[k];
			end
		end
	end

	assign o_products = product_q;

endmodule

// ==== fir/fir_tap_line.sv ====
// sample delay line of NUM_TAPS stages with every stage visible
// shifts on each enabled edge whether or not the sample is valid
// i_clk_ena low freezes all stages
`timescale 1ns/1ps

module fir_tap_line (
	input  logic              clk,
	input  logic              reset,
	input  logic              i_clk_ena,
	input  fir_pkg::sample_t  i_sample,
	output fir_pkg::tap_vec_t o_taps
);
	import fir_pkg::*;

	// tap 0 is the newest sample
	tap_vec_t taps_q;

	// ************************************************
	// shift register
	// ************************************************
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			taps_q <= '0;
		end else if (i_clk_ena) begin
			// oldest sample drops off the far end
			taps_q <= {taps_q[NUM_TAPS-2:0], i_sample};
		end
	end

	// all taps go straight to the pre-adders
	assign o_taps = taps_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the FIR testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f \
	--top-module tb_fir_filter -o sim_fir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/sim_fir > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== source/fir_filter.sv ====
// 42-tap symmetric FIR, 18-bit signed samples, fixed coefficients
// result is the exact convolution modulo 2^18, LATENCY enabled edges late
// no back-pressure, i_clk_ena low stalls the whole pipeline in place
`timescale 1ns/1ps

module fir_filter (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                i_clk_ena,
	input  logic                                i_valid,
	input  logic signed [fir_pkg::SAMPLE_W-1:0] i_in,
	output logic                                o_valid,
	output logic signed [fir_pkg::SAMPLE_W-1:0] o_out
);
	import fir_pkg::*;

	tap_vec_t           taps;
	prod_vec_t          products;
	sample_t            tree_sum;
	logic [LATENCY-1:0] valid_sr;

	// ************************************************
	// datapath
	// ************************************************
	fir_tap_line u_tap_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_in),
		.o_taps    (taps)
	);

	fir_symmetric_mac u_mac (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.o_products (products)
	);

	fir_adder_tree u_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.o_sum      (tree_sum)
	);

	// ************************************************
	// valid delay
	// ************************************************
	// same depth as the datapath so o_valid lines up with o_out
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else if (i_clk_ena) begin
			valid_sr <= {valid_sr[LATENCY-2:0], i_valid};
		end
	end

	assign o_valid = valid_sr[LATENCY-1];
	assign o_out   = tree_sum;

endmodule

// ==== tb/fir_checker.sv ====
// watches the FIR ports and compares o_out and o_valid with a model
// model is a direct 42-tap convolution, reduced modulo 2^18 at the end
// time is counted in enabled edges, stalled edges must leave outputs unchanged
`timescale 1ns/1ps

module fir_checker (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_clk_ena,
	input  logic             i_valid,
	input  fir_pkg::sample_t i_in,
	input  logic             i_dut_valid,
	input  fir_pkg::sample_t i_dut_out,
	input  int               i_phase,
	input  logic             i_drain,
	input  logic             i_finish,
	output int               o_checks,
	output int               o_errors
);
	import fir_pkg::*;
	import fir_coeff_pkg::*;

	// newest sample at index 0
	tap_vec_t hist;
	sample_t  exp_q [$];
	logic     vld_q [$];
	int       edge_q [$];
	int       phase_q [$];
	int       edge_num;
	logic     prev_ena;
	sample_t  prev_out;
	logic     prev_valid;
	int       check_count = 0;
	int       error_count = 0;

	function automatic string phase_name(input int p);
		case (p)
			0:       return "reset";
			1:       return "impulse";
			2:       return "random";
			3:       return "stall";
			4:       return "valid_gap";
			5:       return "wrap";
			default: return "drain";
		endcase
	endfunction

	// full impulse response, second half mirrors the first
	function automatic sample_t coeff_at(input int j);
		if (j < NUM_UNIQ) begin
			return COEFFS[j];
		end
		return COEFFS[NUM_TAPS-1-j];
	endfunction

	// ************************************************
	// reference model
	// ************************************************
	function automatic sample_t expected_out(input tap_vec_t x);
		longint acc;
		acc = 0;
		for (int j = 0; j < NUM_TAPS; j++) begin
			acc += longint'(coeff_at(j)) * longint'(x[j]);
		end
		// low bits only, same result as wrapping at every step
		return acc[SAMPLE_W-1:0];
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("CHECK FAILED %s expected %0d actual %0d", what, expected, actual);
		end
	endtask

	// ************************************************
	// comparison on every rising edge
	// ************************************************
	always @(posedge clk) begin
		if (reset) begin
			hist = '0;
			exp_q.delete();
			vld_q.delete();
			edge_q.delete();
			phase_q.delete();
			edge_num = 0;
			prev_ena = 1'b1;
			prev_out = '0;
			prev_valid = 1'b0;
			check_value("reset out", 0, int'(i_dut_out));
			check_value("reset valid", 0, int'(i_dut_valid));
		end else if (i_finish) begin
			if (exp_q.size() != 0) begin
				error_count++;
				$display("error: %0d expected results were never compared", exp_q.size());
			end
		end else begin
			// outputs only move after an enabled edge
			if (!prev_ena) begin
				check_value({phase_name(i_phase), " hold out"}, int'(prev_out),
					int'(i_dut_out));
				check_value({phase_name(i_phase), " hold valid"}, int'(prev_valid),
					int'(i_dut_valid));
			end
			if (i_clk_ena) begin
				edge_num++;
				hist = {hist[NUM_TAPS-2:0], i_in};
				if (edge_q.size() != 0 && edge_q[0] + LATENCY == edge_num) begin
					check_value({phase_name(phase_q[0]), " out"}, int'(exp_q[0]),
						int'(i_dut_out));
					check_value({phase_name(phase_q[0]), " valid"}, int'(vld_q[0]),
						int'(i_dut_valid));
					void'(exp_q.pop_front());
					void'(vld_q.pop_front());
					void'(edge_q.pop_front());
					void'(phase_q.pop_front());
				end else if (edge_num <= LATENCY) begin
					// pipeline still holds its reset contents
					check_value({phase_name(i_phase), " fill out"}, 0, int'(i_dut_out));
					check_value({phase_name(i_phase), " fill valid"}, 0, int'(i_dut_valid));
				end
				if (!i_drain) begin
					exp_q.push_back(expected_out(hist));
					vld_q.push_back(i_valid);
					edge_q.push_back(edge_num);
					phase_q.push_back(i_phase);
				end
			end
			prev_ena = i_clk_ena;
			prev_out = i_dut_out;
			prev_valid = i_dut_valid;
		end
	end

	assign o_checks = check_count;
	assign o_errors = error_count;

endmodule

// ==== tb/tb_fir_filter.sv ====
// testbench for the 42-tap symmetric FIR
// inputs change on the falling edge and fir_checker compares on the rising edge
// random stimulus uses a fixed seed so every run is identical
`timescale 1ns/1ps

module tb_fir_filter;
	import fir_pkg::*;

	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 2;
	localparam int IMPULSE_TAIL = 50;
	localparam int RANDOM_LEN   = 300;
	localparam int STALL_LEN    = 100;
	localparam int GAP_LEN      = 100;
	localparam int WRAP_LEN     = 80;
	localparam int DRAIN_LEN    = LATENCY + 2;

	// stalls stretch their phase by about half
	localparam int STIM_CYCLES = RESET_CYCLES + 1 + IMPULSE_TAIL + RANDOM_LEN +
		(STALL_LEN * 3) / 2 + GAP_LEN + WRAP_LEN + DRAIN_LEN;
	// more than double the stimulus rounded up to a thousand
	localparam int MAX_CYCLES = ((2 * STIM_CYCLES + 999) / 1000) * 1000;

	// most negative and most positive sample
	localparam sample_t WRAP_MIN = 18'sh20000;
	localparam sample_t WRAP_MAX = 18'sh1FFFF;

	logic        clk;
	logic        reset;
	logic        i_clk_ena;
	logic        i_valid;
	sample_t     i_in;
	logic        o_valid;
	sample_t     o_out;
	int          phase;
	logic        drain;
	logic        finish;
	int          checks;
	int          errors;
	int          cycle_count = 0;

	fir_filter u_fir_filter (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	fir_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.i_clk_ena   (i_clk_ena),
		.i_valid     (i_valid),
		.i_in        (i_in),
		.i_dut_valid (o_valid),
		.i_dut_out   (o_out),
		.i_phase     (phase),
		.i_drain     (drain),
		.i_finish    (finish),
		.o_checks    (checks),
		.o_errors    (errors)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic drive(input logic ena, input logic vld, input sample_t smp);
		@(negedge clk);
		i_clk_ena = ena;
		i_valid = vld;
		i_in = smp;
	endtask

	function automatic sample_t rand_sample();
		logic [31:0] r;
		r = $urandom();
		return r[SAMPLE_W-1:0];
	endfunction

	// ************************************************
	// stimulus phases
	// ************************************************
	initial begin
		int          enabled;
		logic [31:0] r;
		void'($urandom(32'h8310c9bc));
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;
		phase = 0;
		drain = 1'b0;
		finish = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// single 1 then zeros to walk through every coefficient
		phase = 1;
		drive(1'b1, 1'b1, 18'sd1);
		repeat (IMPULSE_TAIL) drive(1'b1, 1'b1, '0);

		phase = 2;
		repeat (RANDOM_LEN) drive(1'b1, 1'b1, rand_sample());

		// enable low about a third of the time
		phase = 3;
		enabled = 0;
		while (enabled < STALL_LEN) begin
			r = $urandom();
			if (r % 3 == 0) begin
				drive(1'b0, 1'b1, rand_sample());
			end else begin
				drive(1'b1, 1'b1, rand_sample());
				enabled++;
			end
		end

		phase = 4;
		repeat (GAP_LEN) begin
			r = $urandom();
			drive(1'b1, r[0], rand_sample());
		end

		phase = 5;
		repeat (WRAP_LEN) begin
			r = $urandom();
			drive(1'b1, 1'b1, r[0] ? WRAP_MAX : WRAP_MIN);
		end

		// flush the last results out of the pipeline
		phase = 6;
		drive(1'b1, 1'b0, '0);
		drain = 1'b1;
		repeat (DRAIN_LEN - 1) drive(1'b1, 1'b0, '0);
		@(negedge clk);
		finish = 1'b1;
		@(posedge clk);
		#1;
		$display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle_count);
		if (errors == 0 && checks > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
